// File: rtl/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// wavefront tagging
`define LSU_WF_ID_W 3
`define LSU_NUM_WF 8

// vector geometry
`define LSU_LANES 4
`define LSU_DWORDS 4
`define LSU_LANE_W 128

// destination field, class in the top two bits
`define LSU_DEST_W 12
`define LSU_SGPR_ADDR_W 9
`define LSU_VGPR_ADDR_W 10

`define LSU_RESP_DEPTH 4
`define LSU_RETIRE_DEPTH 4

`endif

// File: rtl/lsu_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

   // memory response as it comes back from the memory side
   typedef struct packed {
      logic [`LSU_WF_ID_W-1:0] wfid;
      logic [`LSU_LANES*`LSU_LANE_W-1:0] data;
   } lsu_resp_t;

   // what an outstanding memory instruction expects on return
   typedef struct packed {
      logic is_load;
      logic [`LSU_DEST_W-1:0] dest;
      logic [`LSU_DWORDS-1:0] wr_en;
      logic [`LSU_LANES-1:0] exec_mask;
      logic [31:0] pc;
      logic gm_or_lds;             // 1 = global, 0 = lds
   } lsu_issue_rec_t;

   // record for the trace monitor
   typedef struct packed {
      logic [`LSU_WF_ID_W-1:0] wfid;
      logic [31:0] pc;
      logic gm_or_lds;
   } lsu_retire_t;

   // encoding follows dest[11:10], 01 folds into none
   typedef enum logic [1:0] {
      dest_none = 2'b00,
      dest_vgpr = 2'b10,
      dest_sgpr = 2'b11
   } lsu_dest_class_e;

endpackage

`default_nettype wire

// File: rtl/lsu_tag_table.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_tag_table
(
   input  logic                       clk,
   input  logic                       rst_n,

   // issue side
   input  logic                       wr_valid,
   input  logic [`LSU_WF_ID_W-1:0]    wr_wfid,
   input  lsu_pkg::lsu_issue_rec_t    wr_rec,
   output logic                       wr_busy,

   // response lookup
   input  logic [`LSU_WF_ID_W-1:0]    rd_wfid,
   output lsu_pkg::lsu_issue_rec_t    rd_rec,
   output logic                       rd_busy,

   // release from the control
   input  logic                       free_valid,
   input  logic [`LSU_WF_ID_W-1:0]    free_wfid
);

   import lsu_pkg::*;

   lsu_issue_rec_t recs [`LSU_NUM_WF];
   logic [`LSU_NUM_WF-1:0] busy;

   // record storage, only meaningful while busy
   always_ff @(posedge clk)
   begin
      if (wr_valid)
      begin
         recs[wr_wfid] <= wr_rec;
      end
   end

   // issue only hits idle entries and free only hits busy ones,
   // so the two never collide on one index
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         busy <= '0;
      end
      else
      begin
         if (wr_valid)
         begin
            busy[wr_wfid] <= 1'b1;
         end
         if (free_valid)
         begin
            busy[free_wfid] <= 1'b0;
         end
      end
   end

   assign rd_rec  = recs[rd_wfid];   // combinational lookup
   assign rd_busy = busy[rd_wfid];
   assign wr_busy = busy[wr_wfid];

endmodule

`default_nettype wire

// File: rtl/lsu_resp_fifo.sv
`default_nettype none

module lsu_resp_fifo
#(
   parameter type payload_t = logic,
   parameter int  depth     = 4
)
(
   input  logic     clk,
   input  logic     rst_n,

   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,

   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t mem [depth];

   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic push;
   logic pop;

   assign in_ready  = (count != cnt_w'(depth));
   assign out_valid = (count != '0);
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;
   assign out_data  = mem[rd_ptr];   // head shows without a pop

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/lsu_wb_router.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_wb_router
(
   input  logic                                 ack,
   input  logic                                 is_load,
   input  logic [`LSU_DEST_W-1:0]               dest,
   input  logic [`LSU_DWORDS-1:0]               wr_en_in,
   input  logic [`LSU_LANES-1:0]                exec_mask,
   input  logic [`LSU_LANES*`LSU_LANE_W-1:0]    data,

   output logic [`LSU_SGPR_ADDR_W-1:0]          sgpr_addr,
   output logic [`LSU_LANE_W-1:0]               sgpr_data,
   output logic [`LSU_DWORDS-1:0]               sgpr_wr_en,
   output logic                                 sgpr_done,

   output logic [`LSU_VGPR_ADDR_W-1:0]          vgpr_addr,
   output logic [`LSU_LANES*`LSU_LANE_W-1:0]    vgpr_data,
   output logic [`LSU_DWORDS-1:0]               vgpr_wr_en,
   output logic [`LSU_LANES-1:0]                vgpr_wr_mask,
   output logic                                 vgpr_done,

   output lsu_pkg::lsu_dest_class_e             dest_class,
   output logic                                 wr_req
);

   import lsu_pkg::*;

   logic [`LSU_DWORDS-1:0] sgpr_en_raw;
   logic [`LSU_DWORDS-1:0] vgpr_en_raw;
   logic sgpr_done_raw;
   logic vgpr_done_raw;

   always_comb
   begin
      case (dest[`LSU_DEST_W-1 -: 2])
         2'b10:   dest_class = dest_vgpr;
         2'b11:   dest_class = dest_sgpr;
         default: dest_class = dest_none;
      endcase
   end

   // {load, class} decode, ack applied afterwards
   always_comb
   begin
      sgpr_en_raw   = '0;
      vgpr_en_raw   = '0;
      sgpr_done_raw = 1'b0;
      vgpr_done_raw = 1'b0;
      case ({is_load, dest_class})
         {1'b1, dest_vgpr}:
         begin
            vgpr_en_raw   = wr_en_in;
            vgpr_done_raw = 1'b1;
         end
         {1'b1, dest_sgpr}:
         begin
            sgpr_en_raw   = wr_en_in;
            sgpr_done_raw = 1'b1;
         end
         {1'b0, dest_vgpr}: vgpr_done_raw = 1'b1;   // store, done only
         {1'b0, dest_sgpr}: sgpr_done_raw = 1'b1;
         default: ;                                  // no register
      endcase
   end

   assign sgpr_addr    = dest[`LSU_SGPR_ADDR_W-1:0];
   assign sgpr_data    = data[`LSU_LANE_W-1:0];     // lane 0
   assign vgpr_addr    = dest[`LSU_VGPR_ADDR_W-1:0];
   assign vgpr_data    = data;
   assign vgpr_wr_mask = exec_mask;

   assign sgpr_wr_en = ack ? sgpr_en_raw : '0;
   assign vgpr_wr_en = ack ? vgpr_en_raw : '0;
   assign sgpr_done  = ack & sgpr_done_raw;
   assign vgpr_done  = ack & vgpr_done_raw;

   // ungated so the control can decide on it before ack
   assign wr_req = (|sgpr_en_raw) | (|vgpr_en_raw);

endmodule

`default_nettype wire

// File: rtl/lsu_wb_ctrl.sv
`default_nettype none

module lsu_wb_ctrl
(
   input  logic clk,
   input  logic rst_n,

   // response fifo head
   input  logic head_valid,
   output logic head_ready,

   input  logic entry_busy,    // tag table entry for the head's wfid
   input  logic wr_req,        // router wants a register write
   input  logic rf_ready,
   input  logic retire_room,

   output logic retire_push,
   output logic free_valid,
   output logic ack,
   output logic err_unexpected
);

   logic fire;
   logic drop;
   logic err_q;

   always_comb
   begin
      fire = head_valid & entry_busy & (rf_ready | ~wr_req) & retire_room;
      drop = head_valid & ~entry_busy;   // nobody waiting for this one
   end

   assign head_ready  = fire | drop;
   assign ack         = fire;
   assign free_valid  = fire;
   assign retire_push = fire;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         err_q <= 1'b0;
      end
      else
      begin
         err_q <= drop;
      end
   end

   assign err_unexpected = err_q;

endmodule

`default_nettype wire

// File: rtl/lsu_wb_top.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_wb_top
(
   input  logic                                 clk,
   input  logic                                 rst_n,

   // issue
   input  logic                                 issue_valid,
   output logic                                 issue_ready,
   input  logic [`LSU_WF_ID_W-1:0]              issue_wfid,
   input  logic                                 issue_is_load,
   input  logic [`LSU_DEST_W-1:0]               issue_dest,
   input  logic [`LSU_DWORDS-1:0]               issue_wr_en,
   input  logic [`LSU_LANES-1:0]                issue_exec_mask,
   input  logic [31:0]                          issue_pc,
   input  logic                                 issue_gm_or_lds,

   // memory response
   input  logic                                 resp_valid,
   output logic                                 resp_ready,
   input  logic [`LSU_WF_ID_W-1:0]              resp_wfid,
   input  logic [`LSU_LANES*`LSU_LANE_W-1:0]    resp_data,

   // trace monitor retire
   output logic                                 retire_valid,
   input  logic                                 retire_ready,
   output logic [`LSU_WF_ID_W-1:0]              retire_wfid,
   output logic [31:0]                          retire_pc,
   output logic                                 retire_gm_or_lds,

   // register file write
   input  logic                                 rf_ready,
   output logic [`LSU_SGPR_ADDR_W-1:0]          sgpr_addr,
   output logic [`LSU_LANE_W-1:0]               sgpr_data,
   output logic [`LSU_DWORDS-1:0]               sgpr_wr_en,
   output logic                                 sgpr_done,
   output logic [`LSU_VGPR_ADDR_W-1:0]          vgpr_addr,
   output logic [`LSU_LANES*`LSU_LANE_W-1:0]    vgpr_data,
   output logic [`LSU_DWORDS-1:0]               vgpr_wr_en,
   output logic [`LSU_LANES-1:0]                vgpr_wr_mask,
   output logic                                 vgpr_done,
   output logic                                 rfa_wr_req,

   output logic                                 err_unexpected
);

   import lsu_pkg::*;

   lsu_issue_rec_t issue_rec;
   lsu_issue_rec_t head_rec;
   lsu_resp_t      resp_in;
   lsu_resp_t      head;
   lsu_retire_t    retire_in;
   lsu_retire_t    retire_out;

   logic issue_busy;
   logic head_valid;
   logic head_ready;
   logic entry_busy;
   logic wr_req;
   logic ack;
   logic free_valid;
   logic retire_push;
   logic retire_room;

   assign issue_rec = '{is_load:   issue_is_load,
                        dest:      issue_dest,
                        wr_en:     issue_wr_en,
                        exec_mask: issue_exec_mask,
                        pc:        issue_pc,
                        gm_or_lds: issue_gm_or_lds};
   assign issue_ready = ~issue_busy;

   assign resp_in = '{wfid: resp_wfid, data: resp_data};

   assign retire_in = '{wfid: head.wfid, pc: head_rec.pc, gm_or_lds: head_rec.gm_or_lds};
   assign retire_wfid      = retire_out.wfid;
   assign retire_pc        = retire_out.pc;
   assign retire_gm_or_lds = retire_out.gm_or_lds;

   assign rfa_wr_req = (|sgpr_wr_en) | (|vgpr_wr_en);

   lsu_tag_table u_tag_table (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_valid   (issue_valid & issue_ready),
      .wr_wfid    (issue_wfid),
      .wr_rec     (issue_rec),
      .wr_busy    (issue_busy),
      .rd_wfid    (head.wfid),
      .rd_rec     (head_rec),
      .rd_busy    (entry_busy),
      .free_valid (free_valid),
      .free_wfid  (head.wfid)
   );

   lsu_resp_fifo #(.payload_t(lsu_resp_t), .depth(`LSU_RESP_DEPTH)) u_resp_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (resp_valid),
      .in_ready  (resp_ready),
      .in_data   (resp_in),
      .out_valid (head_valid),
      .out_ready (head_ready),
      .out_data  (head)
   );

   lsu_wb_router u_router (
      .ack          (ack),
      .is_load      (head_rec.is_load),
      .dest         (head_rec.dest),
      .wr_en_in     (head_rec.wr_en),
      .exec_mask    (head_rec.exec_mask),
      .data         (head.data),
      .sgpr_addr    (sgpr_addr),
      .sgpr_data    (sgpr_data),
      .sgpr_wr_en   (sgpr_wr_en),
      .sgpr_done    (sgpr_done),
      .vgpr_addr    (vgpr_addr),
      .vgpr_data    (vgpr_data),
      .vgpr_wr_en   (vgpr_wr_en),
      .vgpr_wr_mask (vgpr_wr_mask),
      .vgpr_done    (vgpr_done),
      .dest_class   (),
      .wr_req       (wr_req)
   );

   lsu_wb_ctrl u_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .head_valid     (head_valid),
      .head_ready     (head_ready),
      .entry_busy     (entry_busy),
      .wr_req         (wr_req),
      .rf_ready       (rf_ready),
      .retire_room    (retire_room),
      .retire_push    (retire_push),
      .free_valid     (free_valid),
      .ack            (ack),
      .err_unexpected (err_unexpected)
   );

   lsu_resp_fifo #(.payload_t(lsu_retire_t), .depth(`LSU_RETIRE_DEPTH)) u_retire_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (retire_push),
      .in_ready  (retire_room),
      .in_data   (retire_in),
      .out_valid (retire_valid),
      .out_ready (retire_ready),
      .out_data  (retire_out)
   );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk   = 1'b0;
      rst_n = 1'b0;
      forever #50 clk = ~clk;   // period 100
   end

   initial
   begin
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/lsu_wb_asserts.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_wb_asserts
(
   input wire logic                          clk,
   input wire logic                          rst_n,
   input wire logic [`LSU_DWORDS-1:0]        sgpr_wr_en,
   input wire logic [`LSU_DWORDS-1:0]        vgpr_wr_en,
   input wire logic                          sgpr_done,
   input wire logic                          vgpr_done,
   input wire logic                          rfa_wr_req,
   input wire logic                          rf_ready,
   input wire logic                          retire_valid,
   input wire logic                          retire_ready,
   input wire logic [`LSU_WF_ID_W-1:0]       retire_wfid,
   input wire logic [31:0]                   retire_pc,
   input wire logic                          retire_gm_or_lds,
   input wire logic                          err_unexpected
);

   int fail_count = 0;   // read by the testbench top

   one_rf_class: assert property (@(posedge clk) disable iff (!rst_n)
      !((|sgpr_wr_en) && (|vgpr_wr_en)))
   else
   begin
      fail_count++;
      $error("sgpr and vgpr write enables both active");
   end

   req_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
      rfa_wr_req |-> rf_ready)
   else
   begin
      fail_count++;
      $error("register write requested without rf_ready");
   end

   // payload held until the monitor takes it
   retire_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (retire_valid && !retire_ready) |=>
         (retire_valid && $stable({retire_wfid, retire_pc, retire_gm_or_lds})))
   else
   begin
      fail_count++;
      $error("retire payload changed before it was accepted");
   end

   quiet_in_reset: assert property (@(posedge clk)
      (!rst_n && $past(rst_n) == 1'b0) |->
         (sgpr_wr_en == '0 && vgpr_wr_en == '0 && !sgpr_done && !vgpr_done &&
          !rfa_wr_req && !retire_valid && !err_unexpected))
   else
   begin
      fail_count++;
      $error("control output active during reset");
   end

endmodule

bind lsu_wb_top lsu_wb_asserts u_asserts (
   .clk              (clk),
   .rst_n            (rst_n),
   .sgpr_wr_en       (sgpr_wr_en),
   .vgpr_wr_en       (vgpr_wr_en),
   .sgpr_done        (sgpr_done),
   .vgpr_done        (vgpr_done),
   .rfa_wr_req       (rfa_wr_req),
   .rf_ready         (rf_ready),
   .retire_valid     (retire_valid),
   .retire_ready     (retire_ready),
   .retire_wfid      (retire_wfid),
   .retire_pc        (retire_pc),
   .retire_gm_or_lds (retire_gm_or_lds),
   .err_unexpected   (err_unexpected)
);

`default_nettype wire

// File: testbench/tb_lsu_wb.sv
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu_wb;

   import lsu_pkg::*;

   localparam int num_txn = 48;
   localparam int data_w  = `LSU_LANES*`LSU_LANE_W;

   typedef struct packed {
      logic [`LSU_WF_ID_W-1:0] wfid;
      lsu_issue_rec_t rec;
      logic [data_w-1:0] data;
   } exp_wb_t;

   typedef struct packed {
      logic [`LSU_WF_ID_W-1:0] wfid;
      logic [31:0] pc;
      logic gm_or_lds;
   } exp_ret_t;

   logic clk;
   logic rst_n;
   logic issue_valid;
   logic issue_ready;
   logic [`LSU_WF_ID_W-1:0] issue_wfid;
   logic issue_is_load;
   logic [`LSU_DEST_W-1:0] issue_dest;
   logic [`LSU_DWORDS-1:0] issue_wr_en;
   logic [`LSU_LANES-1:0] issue_exec_mask;
   logic [31:0] issue_pc;
   logic issue_gm_or_lds;
   logic resp_valid;
   logic resp_ready;
   logic [`LSU_WF_ID_W-1:0] resp_wfid;
   logic [data_w-1:0] resp_data;
   logic retire_valid;
   logic retire_ready = 1'b1;
   logic [`LSU_WF_ID_W-1:0] retire_wfid;
   logic [31:0] retire_pc;
   logic retire_gm_or_lds;
   logic rf_ready = 1'b1;
   logic [`LSU_SGPR_ADDR_W-1:0] sgpr_addr;
   logic [`LSU_LANE_W-1:0] sgpr_data;
   logic [`LSU_DWORDS-1:0] sgpr_wr_en;
   logic sgpr_done;
   logic [`LSU_VGPR_ADDR_W-1:0] vgpr_addr;
   logic [data_w-1:0] vgpr_data;
   logic [`LSU_DWORDS-1:0] vgpr_wr_en;
   logic [`LSU_LANES-1:0] vgpr_wr_mask;
   logic vgpr_done;
   logic rfa_wr_req;
   logic err_unexpected;

   integer seed = 32'h3ca5_c500;
   int errors = 0;
   int err_seen = 0;
   int err_expected = 0;
   string cur_test = "reset";
   logic rf_throttle = 1'b0;
   logic ret_throttle = 1'b0;
   logic [`LSU_NUM_WF-1:0] pending = '0;
   lsu_issue_rec_t recs [`LSU_NUM_WF];
   time fire_time [`LSU_NUM_WF];
   time last_accept;
   exp_wb_t exp_wb [$];
   exp_ret_t exp_ret [$];

   tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

   lsu_wb_top dut (.*);

   task automatic check_value(input string what, input logic [data_w-1:0] exp,
                              input logic [data_w-1:0] act);
      assert (exp === act)
      else
      begin
         errors++;
         $display("Error: %s %s expected %0h actual %0h", cur_test, what, exp, act);
      end
   endtask

   function automatic logic [data_w-1:0] rand_data();
      logic [data_w-1:0] d;
      for (int i = 0; i < data_w/32; i++)
      begin
         d[i*32 +: 32] = $random(seed);
      end
      return d;
   endfunction

   task automatic issue_op(input logic [`LSU_WF_ID_W-1:0] wfid, input lsu_issue_rec_t rec);
      logic accepted;
      accepted = 1'b0;
      @(posedge clk);
      issue_valid     <= 1'b1;
      issue_wfid      <= wfid;
      issue_is_load   <= rec.is_load;
      issue_dest      <= rec.dest;
      issue_wr_en     <= rec.wr_en;
      issue_exec_mask <= rec.exec_mask;
      issue_pc        <= rec.pc;
      issue_gm_or_lds <= rec.gm_or_lds;
      while (!accepted)
      begin
         @(negedge clk);
         accepted = issue_ready;
      end
      @(posedge clk);   // transfer edge
      issue_valid <= 1'b0;
      pending[wfid] = 1'b1;
      recs[wfid] = rec;
      last_accept = $time;
   endtask

   task automatic respond(input logic [`LSU_WF_ID_W-1:0] wfid);
      logic accepted;
      logic [data_w-1:0] d;
      accepted = 1'b0;
      d = rand_data();
      @(posedge clk);
      resp_valid <= 1'b1;
      resp_wfid  <= wfid;
      resp_data  <= d;
      while (!accepted)
      begin
         @(negedge clk);
         accepted = resp_ready;
      end
      @(posedge clk);
      resp_valid <= 1'b0;
      if (pending[wfid])
      begin
         exp_wb.push_back('{wfid: wfid, rec: recs[wfid], data: d});
         pending[wfid] = 1'b0;
      end
      else
      begin
         err_expected++;
      end
   endtask

   task automatic drain();
      while (exp_wb.size() != 0 || exp_ret.size() != 0)
      begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);   // let err pulses land
   endtask

   function automatic lsu_issue_rec_t make_rec(input logic is_load, input logic [11:0] dest,
                                               input logic [3:0] wr_en, input logic [3:0] mask);
      lsu_issue_rec_t r;
      r.is_load   = is_load;
      r.dest      = dest;
      r.wr_en     = wr_en;
      r.exec_mask = mask;
      r.pc        = $random(seed);
      r.gm_or_lds = r.pc[0];
      return r;
   endfunction

   // rf and retire throttling
   always @(posedge clk)
   begin
      integer r;
      r = $random(seed);
      rf_ready     <= rf_throttle ? r[0] : 1'b1;
      retire_ready <= ret_throttle ? (r[1] & r[2]) : 1'b1;
   end

   // scoreboard, sampled mid-cycle
   always @(negedge clk)
   begin
      exp_wb_t e;
      exp_ret_t r;
      logic [1:0] cls;
      logic [3:0] v_en;
      logic [3:0] s_en;
      if (rst_n)
      begin
         if (err_unexpected)
         begin
            err_seen++;
         end
         if (retire_valid && retire_ready)
         begin
            if (exp_ret.size() == 0)
            begin
               errors++;
               $display("A retire record came out with none expected");
            end
            else
            begin
               r = exp_ret.pop_front();
               check_value("retire_wfid", r.wfid, retire_wfid);
               check_value("retire_pc", r.pc, retire_pc);
               check_value("retire_gm_or_lds", r.gm_or_lds, retire_gm_or_lds);
            end
         end
         if (dut.u_ctrl.ack)
         begin
            if (exp_wb.size() == 0)
            begin
               errors++;
               $display("A writeback fired with no response expected");
            end
            else
            begin
               e = exp_wb.pop_front();
               cls  = e.rec.dest[11:10];
               v_en = (e.rec.is_load && cls == 2'b10) ? e.rec.wr_en : 4'b0;
               s_en = (e.rec.is_load && cls == 2'b11) ? e.rec.wr_en : 4'b0;
               check_value("vgpr_wr_en", v_en, vgpr_wr_en);
               check_value("sgpr_wr_en", s_en, sgpr_wr_en);
               check_value("vgpr_done", cls == 2'b10, vgpr_done);
               check_value("sgpr_done", cls == 2'b11, sgpr_done);
               check_value("rfa_wr_req", (v_en | s_en) != 4'b0, rfa_wr_req);
               if (v_en != 0)
               begin
                  check_value("vgpr_addr", e.rec.dest[9:0], vgpr_addr);
                  check_value("vgpr_wr_mask", e.rec.exec_mask, vgpr_wr_mask);
                  check_value("vgpr_data", e.data, vgpr_data);
               end
               if (s_en != 0)
               begin
                  check_value("sgpr_addr", e.rec.dest[8:0], sgpr_addr);
                  check_value("sgpr_data", e.data[127:0], sgpr_data);
               end
               exp_ret.push_back('{wfid: e.wfid, pc: e.rec.pc, gm_or_lds: e.rec.gm_or_lds});
               fire_time[e.wfid] = $time;
            end
         end
         else
         begin
            check_value("idle_wr_en", 8'h0, {sgpr_wr_en, vgpr_wr_en});
            check_value("idle_done", 2'b0, {sgpr_done, vgpr_done});
            check_value("idle_wr_req", 1'b0, rfa_wr_req);
         end
      end
   end

   initial
   begin
      #(num_txn * 200 * 100);
      $display("Timeout: the tests did not finish in the allowed time");
      $display("Done: errors found");
      $finish;
   end

   initial
   begin
      int total;
      issue_valid = 1'b0;
      issue_wfid = '0;
      issue_is_load = 1'b0;
      issue_dest = '0;
      issue_wr_en = '0;
      issue_exec_mask = '0;
      issue_pc = '0;
      issue_gm_or_lds = 1'b0;
      resp_valid = 1'b0;
      resp_wfid = '0;
      resp_data = '0;
      while (!rst_n) @(negedge clk);

      cur_test = "vgpr_load";
      issue_op(3'd1, make_rec(1'b1, 12'h85a, 4'b1011, 4'b0110));
      respond(3'd1);
      drain();

      cur_test = "sgpr_load";
      issue_op(3'd2, make_rec(1'b1, 12'hd23, 4'b0001, 4'b1111));
      respond(3'd2);
      drain();

      cur_test = "store_and_none";
      issue_op(3'd3, make_rec(1'b0, 12'h811, 4'b1111, 4'b1111));
      issue_op(3'd4, make_rec(1'b0, 12'hc22, 4'b1111, 4'b1111));
      issue_op(3'd5, make_rec(1'b1, 12'h0ff, 4'b1111, 4'b1111));
      issue_op(3'd6, make_rec(1'b1, 12'h4ab, 4'b1111, 4'b1111));   // class 01
      for (int w = 3; w <= 6; w++)
      begin
         respond(w[2:0]);
      end
      drain();

      cur_test = "rf_backpressure";
      rf_throttle = 1'b1;
      for (int k = 0; k < 8; k++)
      begin
         for (int w = 0; w < 4; w++)
         begin
            issue_op(w[2:0], make_rec(1'b1, {1'b1, k[0] ^ w[0], 10'($random(seed))},
                                      4'($random(seed)) | 4'b0001, 4'($random(seed))));
         end
         for (int w = 0; w < 4; w++)
         begin
            respond(w[2:0]);
         end
      end
      drain();

      cur_test = "retire_order";
      ret_throttle = 1'b1;
      issue_op(3'd1, make_rec(1'b1, 12'h8a0, 4'b1111, 4'b0011));
      issue_op(3'd2, make_rec(1'b0, 12'hc05, 4'b0000, 4'b0001));
      respond(3'd2);
      fork
         issue_op(3'd1, make_rec(1'b1, 12'h801, 4'b0011, 4'b1111));   // busy wfid
         begin
            repeat (8) @(posedge clk);
            respond(3'd1);
         end
      join
      check_value("busy_issue_after_fire", 1'b1, last_accept > fire_time[1]);
      respond(3'd1);
      drain();
      ret_throttle = 1'b0;
      rf_throttle = 1'b0;

      cur_test = "unexpected_resp";
      respond(3'd7);
      drain();
      if (err_seen != err_expected)
      begin
         errors++;
         $display("err_unexpected pulsed %0d times but %0d stray responses were sent",
                  err_seen, err_expected);
      end

      total = errors + dut.u_asserts.fail_count;
      $display("check errors %0d, assertion failures %0d", errors, dut.u_asserts.fail_count);
      if (total == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_tag_table.sv
rtl/lsu_resp_fifo.sv
rtl/lsu_wb_router.sv
rtl/lsu_wb_ctrl.sv
rtl/lsu_wb_top.sv
testbench/tb_clock_gen.sv
testbench/lsu_wb_asserts.sv
testbench/tb_lsu_wb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the writeback testbench, pass is decided from the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module tb_lsu_wb -o sim_lsu_wb &&
./obj_dir/sim_lsu_wb > sim.log 2>&1
cat sim.log
grep -q "^Done: no errors$" sim.log && echo "PASS" || {
   echo "FAIL"
   exit 1
}
